/* Makefile */
TOP := tb_conv3x3

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; \
		echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* hdl/cmd_decoder.sv */
`timescale 1ns/1ps

module cmd_decoder import conv_cmd_pkg::*; #(
  parameter int SIZE_W = 9
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       i_cmd_req,
  input  cmd_word_u  i_cmd_word,
  output logic       o_cmd_ack,
  conv_cfg_if.decoder cfg
);

  typedef enum logic {
    IDLE,
    ACK
  } state_e;

  state_e state_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      cfg.kernel   <= '0;
      cfg.img_size <= '0;
      cfg.shift    <= '0;
      cfg.start    <= 1'b0;
    end else begin
      cfg.start <= 1'b0;
      case (state_q)
        IDLE: begin
          if (i_cmd_req) begin
            state_q <= ACK;
            // opcode is common to both views, then pick the matching one
            case (i_cmd_word.kern_view.op)
              OP_LOAD_KERNEL: begin
                cfg.kernel <= i_cmd_word.kern_view.kernel;
              end
              OP_START: begin
                cfg.img_size <= SIZE_W'(i_cmd_word.start_view.size);
                cfg.shift    <= i_cmd_word.start_view.shift;
                cfg.start    <= 1'b1;
              end
              default: begin
                // unknown opcodes are still acknowledged
              end
            endcase
          end
        end
        ACK: begin
          if (!i_cmd_req) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign o_cmd_ack = (state_q == ACK);

endmodule

/* hdl/conv3x3_top.sv */
`timescale 1ns/1ps

module conv3x3_top import conv_pixel_pkg::*, conv_cmd_pkg::*; #(
  parameter int SIZE_W = 9
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      i_cmd_req,
  input  cmd_word_u i_cmd_word,
  output logic      o_cmd_ack,
  input  logic      i_pix_valid,
  input  pixel_t    i_pix_col0,
  input  pixel_t    i_pix_col1,
  input  pixel_t    i_pix_col2,
  output logic      o_res_valid,
  output pixel_t    o_res_pixel,
  output logic      o_frame_done
);

  logic    win_valid;
  window_t win;
  logic    acc_valid;
  acc_t    acc;

  conv_cfg_if #(.SIZE_W(SIZE_W)) cfg_if ();

  cmd_decoder #(.SIZE_W(SIZE_W)) cmd_decoder_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_cmd_req  (i_cmd_req),
    .i_cmd_word (i_cmd_word),
    .o_cmd_ack  (o_cmd_ack),
    .cfg        (cfg_if.decoder)
  );

  // col0 is the top row of the triple
  window_3x3 #(.SIZE_W(SIZE_W)) window_3x3_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_pix_valid (i_pix_valid),
    .i_pix_col   ({i_pix_col0, i_pix_col1, i_pix_col2}),
    .cfg         (cfg_if.window),
    .o_win_valid (win_valid),
    .o_win       (win)
  );

  conv_mac conv_mac_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_win_valid (win_valid),
    .i_win       (win),
    .cfg         (cfg_if.mac),
    .o_acc_valid (acc_valid),
    .o_acc       (acc)
  );

  result_stage #(.SIZE_W(SIZE_W)) result_stage_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_acc_valid  (acc_valid),
    .i_acc        (acc),
    .cfg          (cfg_if.result),
    .o_res_valid  (o_res_valid),
    .o_res_pixel  (o_res_pixel),
    .o_frame_done (o_frame_done)
  );

endmodule

/* hdl/conv_cfg_if.sv */
`timescale 1ns/1ps

interface conv_cfg_if import conv_pixel_pkg::*; #(
  parameter int SIZE_W = 9
);

  kernel_t           kernel;
  logic [SIZE_W-1:0] img_size;
  logic [3:0]        shift;
  logic              start;

  modport decoder (
    output kernel, img_size, shift, start
  );

  modport window (
    input img_size, start
  );

  modport mac (
    input kernel
  );

  // start clears the output pixel counter
  modport result (
    input img_size, shift, start
  );

endinterface

/* hdl/conv_cmd_pkg.sv */
package conv_cmd_pkg;

  import conv_pixel_pkg::*;

  typedef enum logic [3:0] {
    OP_LOAD_KERNEL = 4'h1,
    OP_START       = 4'h2
  } cmd_op_e;

  // 4 + 36 = 40 bits
  typedef struct packed {
    cmd_op_e op;
    kernel_t kernel;
  } cmd_kernel_t;

  // 4 + 9 + 4 + 23 = 40 bits
  typedef struct packed {
    cmd_op_e     op;
    logic [8:0]  size;
    logic [3:0]  shift;
    logic [22:0] pad;
  } cmd_start_t;

  // the opcode field lines up in both views
  typedef union packed {
    cmd_kernel_t kern_view;
    cmd_start_t  start_view;
  } cmd_word_u;

endpackage

/* hdl/conv_mac.sv */
`timescale 1ns/1ps

module conv_mac import conv_pixel_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       i_win_valid,
  input  window_t    i_win,
  conv_cfg_if.mac    cfg,
  output logic       o_acc_valid,
  output acc_t       o_acc
);

  // 9-bit positive pixel times 4-bit coefficient
  logic signed [12:0] prod_q [9];
  logic               prod_valid_q;
  acc_t               sum;

  always_ff @(posedge clk) begin
    if (i_win_valid) begin
      for (int i = 0; i < 9; i++) begin
        prod_q[i] <= $signed({1'b0, i_win[i]}) * $signed(cfg.kernel[i]);
      end
    end
  end

  always_comb begin
    sum = '0;
    for (int i = 0; i < 9; i++) begin
      sum = sum + acc_t'(prod_q[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid_q) begin
      o_acc <= sum;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prod_valid_q <= 1'b0;
      o_acc_valid  <= 1'b0;
    end else begin
      prod_valid_q <= i_win_valid;
      o_acc_valid  <= prod_valid_q;
    end
  end

endmodule

/* hdl/conv_pixel_pkg.sv */
package conv_pixel_pkg;

  // unsigned greyscale sample
  typedef logic [7:0] pixel_t;

  // signed kernel coefficient, range -8..7
  typedef logic signed [3:0] coeff_t;

  // row-major, index 0 is the top left tap and sits in the MSBs
  typedef coeff_t [0:8] kernel_t;

  // same order as kernel_t, index 4 is the centre pixel
  typedef pixel_t [0:8] window_t;

  // worst case sum is 9 * 255 * -8, which still fits in 16 bits
  typedef logic signed [15:0] acc_t;

endpackage

/* hdl/result_stage.sv */
`timescale 1ns/1ps

module result_stage import conv_pixel_pkg::*; #(
  parameter int SIZE_W = 9
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        i_acc_valid,
  input  acc_t        i_acc,
  conv_cfg_if.result  cfg,
  output logic        o_res_valid,
  output pixel_t      o_res_pixel,
  output logic        o_frame_done
);

  acc_t                shifted;
  pixel_t              clamped;
  logic [2*SIZE_W-1:0] pix_cnt_q;
  logic [2*SIZE_W-1:0] frame_total;

  assign shifted     = i_acc >>> cfg.shift;
  assign frame_total = cfg.img_size * cfg.img_size;

  always_comb begin
    if (shifted < 0) begin
      clamped = '0;
    end else if (shifted > acc_t'(255)) begin
      clamped = 8'hff;
    end else begin
      clamped = shifted[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pix_cnt_q    <= '0;
      o_res_valid  <= 1'b0;
      o_frame_done <= 1'b0;
    end else begin
      o_res_valid  <= i_acc_valid;
      // pixel number N*N closes the frame
      o_frame_done <= i_acc_valid && (pix_cnt_q + 1'b1 == frame_total);
      if (cfg.start) begin
        pix_cnt_q <= '0;
      end else if (i_acc_valid) begin
        pix_cnt_q <= pix_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_acc_valid) begin
      o_res_pixel <= clamped;
    end
  end

endmodule

/* hdl/window_3x3.sv */
`timescale 1ns/1ps

module window_3x3 import conv_pixel_pkg::*; #(
  parameter int SIZE_W = 9
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         i_pix_valid,
  input  pixel_t [0:2] i_pix_col,
  conv_cfg_if.window   cfg,
  output logic         o_win_valid,
  output window_t      o_win
);

  logic              armed_q;
  logic [SIZE_W-1:0] beat_q;
  logic [SIZE_W-1:0] row_q;
  logic              beat_ok;
  logic              last_beat;
  logic              last_row;

  // col_q[2] is the newest column, col_q[0] the oldest
  pixel_t [0:2]      col_q [3];
  logic              emit_q;
  logic              top_q;
  logic              bot_q;
  logic              left_q;
  logic              right_q;
  window_t           win_d;

  assign beat_ok   = armed_q && i_pix_valid;
  assign last_beat = (beat_q == cfg.img_size);
  assign last_row  = (row_q == cfg.img_size - 1'b1);

  // each row takes N+1 beats, the last one only flushes the right column
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      armed_q <= 1'b0;
      beat_q  <= '0;
      row_q   <= '0;
    end else if (cfg.start) begin
      armed_q <= 1'b1;
      beat_q  <= '0;
      row_q   <= '0;
    end else if (beat_ok) begin
      if (last_beat) begin
        beat_q <= '0;
        if (last_row) begin
          row_q   <= '0;
          armed_q <= 1'b0;
        end else begin
          row_q <= row_q + 1'b1;
        end
      end else begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      emit_q <= 1'b0;
    end else begin
      emit_q <= beat_ok && (beat_q != '0);
    end
  end

  // border flags describe the centre at beat-1, captured with the column
  always_ff @(posedge clk) begin
    if (i_pix_valid) begin
      col_q[0] <= col_q[1];
      col_q[1] <= col_q[2];
      col_q[2] <= i_pix_col;
    end
    if (beat_ok) begin
      top_q   <= (row_q == '0);
      bot_q   <= last_row;
      left_q  <= (beat_q == SIZE_W'(1));
      right_q <= last_beat;
    end
  end

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        if ((i == 0 && top_q) || (i == 2 && bot_q) ||
            (j == 0 && left_q) || (j == 2 && right_q)) begin
          win_d[3*i+j] = '0;
        end else begin
          win_d[3*i+j] = col_q[j][i];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_win_valid <= 1'b0;
    end else begin
      o_win_valid <= emit_q;
    end
  end

  always_ff @(posedge clk) begin
    if (emit_q) begin
      o_win <= win_d;
    end
  end

endmodule

/* testbench/conv3x3_assertions.sv */
`timescale 1ns/1ps

module conv3x3_assertions (
  input logic clk,
  input logic rst_n,
  input logic i_cmd_req,
  input logic i_cmd_ack,
  input logic i_res_valid
);

  // acknowledge answers a request that was seen on the previous clock
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(i_cmd_ack) |-> $past(i_cmd_req))
    else $error("command acknowledge rose without a request");

  req_holds_for_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(i_cmd_req) |-> i_cmd_ack)
    else $error("command request dropped before the acknowledge");

  res_quiet_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !i_res_valid ##1 !i_res_valid ##1 !i_res_valid ##1 !i_res_valid)
    else $error("result valid rose within 4 cycles of reset");

endmodule

bind conv3x3_top conv3x3_assertions conv3x3_assertions_inst (
  .clk         (clk),
  .rst_n       (rst_n),
  .i_cmd_req   (i_cmd_req),
  .i_cmd_ack   (o_cmd_ack),
  .i_res_valid (o_res_valid)
);

/* testbench/tb_conv3x3.sv */
`timescale 1ns/1ps

module tb_conv3x3 import conv_pixel_pkg::*, conv_cmd_pkg::*; ();

  logic      clk;
  logic      rst_n;
  logic      i_cmd_req;
  cmd_word_u i_cmd_word;
  logic      o_cmd_ack;
  logic      i_pix_valid;
  pixel_t    i_pix_col0;
  pixel_t    i_pix_col1;
  pixel_t    i_pix_col2;
  logic      o_res_valid;
  pixel_t    o_res_pixel;
  logic      o_frame_done;

  integer    seed;
  int        cyc = 0;
  int        err_pixel = 0;
  int        err_done = 0;
  int        err_latency = 0;
  int        err_other = 0;

  // reference image and kernel that the model works from
  pixel_t    img [0:11][0:11];
  int        kcoef [9];

  pixel_t    exp_pix_q [$];
  logic      exp_done_q [$];
  int        exp_cyc_q [$];

  conv3x3_top conv3x3_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_cmd_req    (i_cmd_req),
    .i_cmd_word   (i_cmd_word),
    .o_cmd_ack    (o_cmd_ack),
    .i_pix_valid  (i_pix_valid),
    .i_pix_col0   (i_pix_col0),
    .i_pix_col1   (i_pix_col1),
    .i_pix_col2   (i_pix_col2),
    .o_res_valid  (o_res_valid),
    .o_res_pixel  (o_res_pixel),
    .o_frame_done (o_frame_done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic check_pixel(pixel_t got, pixel_t exp);
    if (got !== exp) begin
      err_pixel++;
      $display("Fail o_res_pixel: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_frame_done(logic got, logic exp);
    if (got !== exp) begin
      err_done++;
      $display("Fail o_frame_done: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      err_other++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_latency(int got, int exp);
    if (got != exp) begin
      err_latency++;
      $display("Fail o_res_valid cycle: got %h expected %h", got, exp);
    end
  endtask

  // outputs are read on the falling edge, half a period after they change
  always @(negedge clk) begin
    if (rst_n) begin
      if (o_res_valid) begin
        if (exp_pix_q.size() == 0) begin
          err_other++;
          $display("an output pixel %h appeared while no result was pending", o_res_pixel);
        end else begin
          check_pixel(o_res_pixel, exp_pix_q.pop_front());
          check_frame_done(o_frame_done, exp_done_q.pop_front());
          check_latency(cyc, exp_cyc_q.pop_front());
        end
      end else if (o_frame_done) begin
        check_frame_done(o_frame_done, 1'b0);
      end
    end
  end

  task automatic send_cmd(cmd_word_u w);
    int t;
    @(posedge clk);
    #1;
    i_cmd_word = w;
    i_cmd_req  = 1'b1;
    for (t = 0; t < 20 && !o_cmd_ack; t++) begin
      @(posedge clk);
      #1;
    end
    if (!o_cmd_ack) begin
      err_other++;
      $display("the command acknowledge did not rise within 20 cycles");
    end
    i_cmd_req = 1'b0;
    for (t = 0; t < 20 && o_cmd_ack; t++) begin
      @(posedge clk);
      #1;
    end
    if (o_cmd_ack) begin
      err_other++;
      $display("the command acknowledge stayed high after the request dropped");
    end
  endtask

  task automatic load_kernel();
    cmd_word_u w;
    w = '0;
    w.kern_view.op = OP_LOAD_KERNEL;
    for (int i = 0; i < 9; i++) begin
      w.kern_view.kernel[i] = coeff_t'(kcoef[i]);
    end
    send_cmd(w);
  endtask

  task automatic start_frame(int n, int shift);
    cmd_word_u w;
    w = '0;
    w.start_view.op    = OP_START;
    w.start_view.size  = 9'(n);
    w.start_view.shift = 4'(shift);
    send_cmd(w);
  endtask

  task automatic fill_image(int n, int base, int span);
    for (int r = 0; r < n; r++) begin
      for (int c = 0; c < n; c++) begin
        img[r][c] = pixel_t'(base + int'($unsigned($random(seed)) % span));
      end
    end
  endtask

  // zero padding, arithmetic shift and clamp applied to the stored image
  task automatic build_expected(int n, int shift);
    int sum;
    int rr;
    int cc;
    int val;
    for (int r = 0; r < n; r++) begin
      for (int c = 0; c < n; c++) begin
        sum = 0;
        for (int dr = -1; dr <= 1; dr++) begin
          for (int dc = -1; dc <= 1; dc++) begin
            rr = r + dr;
            cc = c + dc;
            if (rr >= 0 && rr < n && cc >= 0 && cc < n) begin
              sum += kcoef[3 * (dr + 1) + dc + 1] * int'(img[rr][cc]);
            end
          end
        end
        val = sum >>> shift;
        if (val < 0) begin
          val = 0;
        end else if (val > 255) begin
          val = 255;
        end
        exp_pix_q.push_back(pixel_t'(val));
        exp_done_q.push_back(r == n - 1 && c == n - 1);
      end
    end
  endtask

  // rows outside the image and the flush beat carry garbage
  function automatic pixel_t image_pixel(int r, int c, int n);
    if (r >= 0 && r < n && c < n) begin
      return img[r][c];
    end
    return pixel_t'($random(seed));
  endfunction

  task automatic drive_frame(int n);
    for (int r = 0; r < n; r++) begin
      for (int c = 0; c <= n; c++) begin
        @(posedge clk);
        #1;
        if ($unsigned($random(seed)) % 5 == 0) begin
          i_pix_valid = 1'b0;
          @(posedge clk);
          #1;
        end
        i_pix_valid = 1'b1;
        i_pix_col0  = image_pixel(r - 1, c, n);
        i_pix_col1  = image_pixel(r, c, n);
        i_pix_col2  = image_pixel(r + 1, c, n);
        // sampled on the next edge, result visible four edges after that
        if (c > 0) begin
          exp_cyc_q.push_back(cyc + 5);
        end
      end
    end
    @(posedge clk);
    #1;
    i_pix_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int t;
    for (t = 0; t < 200 && exp_pix_q.size() != 0; t++) begin
      @(posedge clk);
    end
    if (exp_pix_q.size() != 0) begin
      err_other++;
      $display("timed out with %0d results still missing", exp_pix_q.size());
      exp_pix_q.delete();
      exp_done_q.delete();
      exp_cyc_q.delete();
    end
  endtask

  task automatic run_frame(int n, int shift);
    start_frame(n, shift);
    build_expected(n, shift);
    drive_frame(n);
    wait_drain();
  endtask

  // the monitor flags any output that shows up here
  task automatic send_ignored_beats(int k);
    for (int i = 0; i < k; i++) begin
      @(posedge clk);
      #1;
      i_pix_valid = 1'b1;
      i_pix_col0  = pixel_t'($random(seed));
      i_pix_col1  = pixel_t'($random(seed));
      i_pix_col2  = pixel_t'($random(seed));
    end
    @(posedge clk);
    #1;
    i_pix_valid = 1'b0;
    repeat (8) @(posedge clk);
  endtask

  initial begin
    int n;
    seed        = 32'h7205_8039;
    rst_n       = 1'b0;
    i_cmd_req   = 1'b0;
    i_cmd_word  = '0;
    i_pix_valid = 1'b0;
    i_pix_col0  = '0;
    i_pix_col1  = '0;
    i_pix_col2  = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_flag("o_cmd_ack", o_cmd_ack, 1'b0);
    check_flag("o_res_valid", o_res_valid, 1'b0);
    check_flag("o_frame_done", o_frame_done, 1'b0);

    send_ignored_beats(12);

    for (int i = 0; i < 9; i++) begin
      kcoef[i] = (i == 4) ? 1 : 0;
    end
    load_kernel();
    fill_image(5, 0, 256);
    run_frame(5, 0);
    send_ignored_beats(8);

    repeat (6) begin
      n = 3 + int'($unsigned($random(seed)) % 10);
      for (int i = 0; i < 9; i++) begin
        kcoef[i] = int'($unsigned($random(seed)) % 16) - 8;
      end
      fill_image(n, 0, 256);
      load_kernel();
      run_frame(n, int'($unsigned($random(seed)) % 6));
    end

    // saturation in both directions on a bright image
    fill_image(6, 200, 56);
    for (int i = 0; i < 9; i++) begin
      kcoef[i] = 7;
    end
    load_kernel();
    run_frame(6, 0);
    for (int i = 0; i < 9; i++) begin
      kcoef[i] = -8;
    end
    load_kernel();
    run_frame(6, 0);
    send_ignored_beats(8);

    $display("errors: pixel %0d, frame_done %0d, latency %0d, other %0d",
             err_pixel, err_done, err_latency, err_other);
    if (err_pixel + err_done + err_latency + err_other == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
hdl/conv_pixel_pkg.sv
hdl/conv_cmd_pkg.sv
hdl/conv_cfg_if.sv
hdl/cmd_decoder.sv
hdl/window_3x3.sv
hdl/conv_mac.sv
hdl/result_stage.sv
hdl/conv3x3_top.sv
testbench/conv3x3_assertions.sv
testbench/tb_conv3x3.sv
